// ==== flist.f ====
hw/dma_pkg.sv
hw/burst_counter.sv
hw/burst_tag_fifo.sv
hw/dma_rd_engine.sv
hw/dma_csr.sv
hw/dma_rd_top.sv
test/axi_mem_model.sv
test/tb_dma_rd.sv

// ==== hw/burst_counter.sv ====
// Remaining burst counter

`timescale 1ns/100ps

module burst_counter #(
  parameter int width = 8
) (
  input  logic             aclk,
  input  logic             aresetn,
  input  logic             load,
  input  logic             decr,
  input  logic [width-1:0] load_value,
  output logic             is_zero
);

  // Bursts left after the one being presented
  logic [width-1:0] count;

  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      count <= '0;
    end else if (load) begin
      // New transfer wins over a pending step
      count <= load_value;
    end else if (decr && !is_zero) begin
      count <= count - 1'b1;
    end
  end

  // Final burst is the next one out
  assign is_zero = (count == '0);

endmodule

// ==== hw/burst_tag_fifo.sv ====
// Outstanding burst tag FIFO

`timescale 1ns/100ps

module burst_tag_fifo #(
  parameter int depth = 4,
  parameter int width = 1
) (
  input  logic             aclk,
  input  logic             aresetn,
  input  logic             push,
  input  logic [width-1:0] tag_in,
  input  logic             pop,
  output logic             space_ok,
  output logic [width-1:0] tag_out
);

  // Pointer at least one bit wide so depth 1 also builds
  localparam int ptr_bits = (depth > 1) ? $clog2(depth) : 1;
  localparam int cnt_bits = $clog2(depth + 1);

  logic [width-1:0]    mem [0:depth-1];
  logic [ptr_bits-1:0] wr_ptr;
  logic [ptr_bits-1:0] rd_ptr;
  logic [cnt_bits-1:0] fill;

  // Tag storage, one entry per burst in flight
  always_ff @(posedge aclk) begin
    if (push) begin
      mem[wr_ptr] <= tag_in;
    end
  end

  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      fill   <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == ptr_bits'(depth - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == ptr_bits'(depth - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // Fill level tracks bursts issued but not yet finished
      if (push && !pop) begin
        fill <= fill + 1'b1;
      end else if (pop && !push) begin
        fill <= fill - 1'b1;
      end
    end
  end

  // Oldest burst's tag
  assign tag_out  = mem[rd_ptr];
  assign space_ok = (fill != cnt_bits'(depth));

endmodule

// ==== hw/dma_csr.sv ====
// DMA host register block

`timescale 1ns/100ps

module dma_csr (
  input  logic                              aclk,
  input  logic                              aresetn,

  // Four-phase host port
  input  logic                              csr_req,
  input  logic                              csr_we,
  input  logic [dma_pkg::reg_addr_bits-1:0] csr_addr,
  input  logic [31:0]                       csr_wdata,
  output logic                              csr_ack,
  output logic [31:0]                       csr_rdata,

  // Command to the engine
  output logic                              cmd_valid,
  input  logic                              cmd_ready,
  output logic [dma_pkg::addr_bits-1:0]     cmd_addr,
  output logic [dma_pkg::len_bits-1:0]      cmd_len,
  output logic                              cmd_notify,
  input  logic                              xfer_done
);

  import dma_pkg::*;

  localparam int burst_lsb = log_data_bytes + log_burst_len;

  logic                     access;
  logic                     wr_access;
  logic                     start_wr;
  logic                     busy;
  logic [done_cnt_bits-1:0] done_cnt;
  logic [31:0]              rd_word;

  ////////////////////////////////////////
  // Handshake
  ////////////////////////////////////////

  // New request seen while ack is low
  assign access    = csr_req & ~csr_ack;
  assign wr_access = access & csr_we;
  assign start_wr  = wr_access & (csr_addr == reg_ctrl) & csr_wdata[ctrl_start_bit];

  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      csr_ack <= 1'b0;
    end else if (access) begin
      csr_ack <= 1'b1;
    end else if (!csr_req) begin
      // Second half of the handshake
      csr_ack <= 1'b0;
    end
  end

  ////////////////////////////////////////
  // Registers and launch
  ////////////////////////////////////////

  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      cmd_addr   <= '0;
      cmd_len    <= '0;
      cmd_notify <= 1'b0;
      cmd_valid  <= 1'b0;
      done_cnt   <= '0;
    end else begin
      // Low bits forced to keep the alignment rule
      if (wr_access && csr_addr == reg_src_addr) begin
        cmd_addr <= {csr_wdata[addr_bits-1:burst_lsb], burst_lsb'(0)};
      end
      if (wr_access && csr_addr == reg_len) begin
        cmd_len <= {csr_wdata[len_bits-1:log_data_bytes], log_data_bytes'(0)};
      end
      // Launch rises together with ack
      if (start_wr) begin
        cmd_notify <= csr_wdata[ctrl_notify_bit];
        cmd_valid  <= 1'b1;
      end else if (cmd_ready) begin
        cmd_valid  <= 1'b0;
      end
      // Wrapping count of finished notify transfers
      if (xfer_done) begin
        done_cnt <= done_cnt + 1'b1;
      end
    end
  end

  ////////////////////////////////////////
  // Read back
  ////////////////////////////////////////

  assign busy = cmd_valid | ~cmd_ready;

  always_comb begin
    rd_word = '0;
    case (csr_addr)
      reg_src_addr: rd_word = cmd_addr;
      reg_len:      rd_word = 32'(cmd_len);
      reg_ctrl: begin
        rd_word[ctrl_start_bit]  = cmd_valid;
        rd_word[ctrl_notify_bit] = cmd_notify;
      end
      default: begin
        rd_word[stat_busy_bit]                          = busy;
        rd_word[stat_done_lsb +: done_cnt_bits]         = done_cnt;
      end
    endcase
  end

  // Data valid from the ack edge on
  always_ff @(posedge aclk) begin
    if (access) begin
      csr_rdata <= rd_word;
    end
  end

endmodule

// ==== hw/dma_pkg.sv ====
// Read DMA shared constants

package dma_pkg;

  ////////////////////////////////////////
  // Bus widths
  ////////////////////////////////////////

  // AXI and stream data path
  localparam int data_bits      = 64;
  localparam int data_bytes     = data_bits / 8;
  localparam int log_data_bytes = $clog2(data_bytes);
  localparam int addr_bits      = 32;

  // Byte length field of a transfer
  localparam int len_bits       = 20;

  ////////////////////////////////////////
  // Burst geometry
  ////////////////////////////////////////

  localparam int burst_len       = 16;
  localparam int log_burst_len   = $clog2(burst_len);
  // Address step per burst
  localparam int burst_bytes     = burst_len * data_bytes;
  localparam int max_outstanding = 4;
  // Bursts per transfer, fits the largest length
  localparam int burst_cnt_bits  = len_bits - log_burst_len - log_data_bytes;

  // Fixed AR attributes, INCR bursts only
  localparam logic [1:0] ar_burst_incr = 2'b01;
  localparam logic [3:0] ar_cache_val  = 4'b0011;
  localparam logic [2:0] ar_prot_val   = 3'b000;

  ////////////////////////////////////////
  // Register map
  ////////////////////////////////////////

  localparam int reg_addr_bits = 2;

  localparam logic [reg_addr_bits-1:0] reg_src_addr = 2'd0;
  localparam logic [reg_addr_bits-1:0] reg_len      = 2'd1;
  localparam logic [reg_addr_bits-1:0] reg_ctrl     = 2'd2;
  localparam logic [reg_addr_bits-1:0] reg_status   = 2'd3;

  // Field positions in ctrl and status
  localparam int ctrl_start_bit  = 0;
  localparam int ctrl_notify_bit = 1;
  localparam int stat_busy_bit   = 0;
  localparam int stat_done_lsb   = 8;

  localparam int done_cnt_bits = 8;

endpackage

// ==== hw/dma_rd_engine.sv ====
// AXI4 read burst engine

`timescale 1ns/100ps

module dma_rd_engine (
  input  logic                          aclk,
  input  logic                          aresetn,

  // Command from the register block
  input  logic                          cmd_valid,
  output logic                          cmd_ready,
  input  logic [dma_pkg::addr_bits-1:0] cmd_addr,
  input  logic [dma_pkg::len_bits-1:0]  cmd_len,
  input  logic                          cmd_notify,
  output logic                          xfer_done,

  // AXI4 read address
  output logic [dma_pkg::addr_bits-1:0] araddr,
  output logic [7:0]                    arlen,
  output logic [2:0]                    arsize,
  output logic [1:0]                    arburst,
  output logic [3:0]                    arcache,
  output logic [2:0]                    arprot,
  output logic                          arvalid,
  input  logic                          arready,

  // AXI4 read data
  input  logic [dma_pkg::data_bits-1:0] rdata,
  input  logic                          rlast,
  input  logic                          rvalid,
  output logic                          rready,

  // Output stream
  output logic [dma_pkg::data_bits-1:0] axis_tdata,
  output logic                          axis_tlast,
  output logic                          axis_tvalid,
  input  logic                          axis_tready
);

  import dma_pkg::*;

  localparam int beat_lsb  = log_data_bytes;
  localparam int burst_lsb = log_data_bytes + log_burst_len;

  logic                      cmd_accept;
  logic                      start;
  logic [burst_cnt_bits-1:0] num_full;
  logic                      has_partial;
  logic [burst_cnt_bits-1:0] num_bursts_m1;
  logic [log_burst_len-1:0]  final_len;
  logic                      notify_r;
  logic [addr_bits-1:0]      addr_r;
  logic                      arvalid_r;
  logic                      ar_idle;
  logic                      arxfer;
  logic                      ar_final;
  logic                      rxfer;
  logic                      space_ok;
  // Bit 1 marks the transfer's last burst, bit 0 its notify request
  logic [1:0]                tag_in;
  logic [1:0]                tag_out;

  ////////////////////////////////////////
  // Command decode
  ////////////////////////////////////////

  assign cmd_ready  = ar_idle;
  assign cmd_accept = cmd_valid & cmd_ready;

  // Whole bursts plus a possible short tail
  assign num_full    = cmd_len[len_bits-1:burst_lsb];
  assign has_partial = |cmd_len[burst_lsb-1:beat_lsb];

  // Counter load one cycle after accept
  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      start <= 1'b0;
    end else begin
      start <= cmd_accept;
    end
  end

  // Transfer parameters
  always_ff @(posedge aclk) begin
    if (cmd_accept) begin
      num_bursts_m1 <= has_partial ? num_full : num_full - 1'b1;
      // Wraps to 15 when the tail is empty
      final_len     <= cmd_len[burst_lsb-1:beat_lsb] - 1'b1;
      notify_r      <= cmd_notify;
    end
  end

  ////////////////////////////////////////
  // Read address channel
  ////////////////////////////////////////

  assign arxfer  = arvalid_r & arready;
  assign arvalid = arvalid_r;
  assign araddr  = addr_r;
  assign arlen   = ar_final ? {4'b0000, final_len} : 8'(burst_len - 1);
  assign arsize  = 3'(log_data_bytes);
  assign arburst = ar_burst_incr;
  assign arcache = ar_cache_val;
  assign arprot  = ar_prot_val;

  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      arvalid_r <= 1'b0;
      ar_idle   <= 1'b1;
    end else begin
      // Gap of one cycle between bursts, gated by tag space
      if (!ar_idle && !arvalid_r && space_ok) begin
        arvalid_r <= 1'b1;
      end else if (arready) begin
        arvalid_r <= 1'b0;
      end
      if (cmd_accept) begin
        ar_idle <= 1'b0;
      end else if (arxfer && ar_final) begin
        ar_idle <= 1'b1;
      end
    end
  end

  // Burst address walks in 128 byte steps
  always_ff @(posedge aclk) begin
    if (cmd_accept) begin
      addr_r <= cmd_addr;
    end else if (arxfer) begin
      addr_r <= addr_r + addr_bits'(burst_bytes);
    end
  end

  burst_counter #(
    .width      (burst_cnt_bits)
  ) i_burst_cnt (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .load       (start),
    .decr       (arxfer),
    .load_value (num_bursts_m1),
    .is_zero    (ar_final)
  );

  ////////////////////////////////////////
  // Read data to stream
  ////////////////////////////////////////

  assign tag_in = {ar_final, ar_final & notify_r};

  burst_tag_fifo #(
    .depth    (max_outstanding),
    .width    (2)
  ) i_tag_fifo (
    .aclk     (aclk),
    .aresetn  (aresetn),
    .push     (arxfer),
    .tag_in   (tag_in),
    .pop      (rxfer & rlast),
    .space_ok (space_ok),
    .tag_out  (tag_out)
  );

  // Straight pass, no buffering
  assign rxfer       = rvalid & rready;
  assign rready      = axis_tready;
  assign axis_tvalid = rvalid;
  assign axis_tdata  = rdata;
  assign axis_tlast  = rlast & tag_out[1];

  // Final beat of a notify transfer leaves
  assign xfer_done = rxfer & rlast & tag_out[0];

endmodule

// ==== hw/dma_rd_top.sv ====
// Read DMA top level

`timescale 1ns/100ps

module dma_rd_top (
  input  logic                              aclk,
  input  logic                              aresetn,

  // Host register port
  input  logic                              csr_req,
  input  logic                              csr_we,
  input  logic [dma_pkg::reg_addr_bits-1:0] csr_addr,
  input  logic [31:0]                       csr_wdata,
  output logic                              csr_ack,
  output logic [31:0]                       csr_rdata,

  // AXI4 read master
  output logic [dma_pkg::addr_bits-1:0]     araddr,
  output logic [7:0]                        arlen,
  output logic [2:0]                        arsize,
  output logic [1:0]                        arburst,
  output logic [3:0]                        arcache,
  output logic [2:0]                        arprot,
  output logic                              arvalid,
  input  logic                              arready,
  input  logic [dma_pkg::data_bits-1:0]     rdata,
  input  logic                              rlast,
  input  logic                              rvalid,
  output logic                              rready,

  // Output stream
  output logic [dma_pkg::data_bits-1:0]     axis_tdata,
  output logic                              axis_tlast,
  output logic                              axis_tvalid,
  input  logic                              axis_tready
);

  // Command and completion between the two blocks
  logic                          cmd_valid;
  logic                          cmd_ready;
  logic [dma_pkg::addr_bits-1:0] cmd_addr;
  logic [dma_pkg::len_bits-1:0]  cmd_len;
  logic                          cmd_notify;
  logic                          xfer_done;

  dma_csr i_csr (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .csr_req   (csr_req),
    .csr_we    (csr_we),
    .csr_addr  (csr_addr),
    .csr_wdata (csr_wdata),
    .csr_ack   (csr_ack),
    .csr_rdata (csr_rdata),
    .cmd_valid (cmd_valid),
    .cmd_ready (cmd_ready),
    .cmd_addr  (cmd_addr),
    .cmd_len   (cmd_len),
    .cmd_notify(cmd_notify),
    .xfer_done (xfer_done)
  );

  dma_rd_engine i_engine (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .cmd_valid  (cmd_valid),
    .cmd_ready  (cmd_ready),
    .cmd_addr   (cmd_addr),
    .cmd_len    (cmd_len),
    .cmd_notify (cmd_notify),
    .xfer_done  (xfer_done),
    .araddr     (araddr),
    .arlen      (arlen),
    .arsize     (arsize),
    .arburst    (arburst),
    .arcache    (arcache),
    .arprot     (arprot),
    .arvalid    (arvalid),
    .arready    (arready),
    .rdata      (rdata),
    .rlast      (rlast),
    .rvalid     (rvalid),
    .rready     (rready),
    .axis_tdata (axis_tdata),
    .axis_tlast (axis_tlast),
    .axis_tvalid(axis_tvalid),
    .axis_tready(axis_tready)
  );

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the read DMA testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module tb_dma_rd \
  -Mdir obj_dir -o tb_dma_rd
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit "$status"
fi

./obj_dir/tb_dma_rd
status=$?
if [ "$status" -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit "$status"
fi

echo "Simulation finished cleanly"
exit 0

// ==== test/axi_mem_model.sv ====
// AXI read slave model

`timescale 1ns/100ps

module axi_mem_model (
  input  logic                          aclk,
  input  logic                          aresetn,

  // Read address
  input  logic [dma_pkg::addr_bits-1:0] araddr,
  input  logic [7:0]                    arlen,
  input  logic                          arvalid,
  output logic                          arready,

  // Read data
  output logic [dma_pkg::data_bits-1:0] rdata,
  output logic                          rlast,
  output logic                          rvalid,
  input  logic                          rready,

  // Stall requests drawn from the testbench LFSR
  input  logic                          ar_stall,
  input  logic                          r_stall
);

  import dma_pkg::*;

  localparam int queue_depth = 8;

  // Accepted bursts, oldest first
  logic [addr_bits-1:0] burst_addr [$];
  logic [7:0]           burst_last [$];
  logic [7:0]           beat;
  logic                 in_reset;
  logic                 ar_hs;
  logic                 r_hs;
  logic                 ar_hold;
  logic                 r_hold;
  logic [addr_bits-1:0] ar_addr_s;
  logic [7:0]           ar_len_s;
  logic [addr_bits-1:0] beat_addr;

  initial begin
    arready = 1'b0;
    rvalid  = 1'b0;
    rlast   = 1'b0;
    rdata   = '0;
    beat    = '0;
    forever begin
      // Mid-cycle sample, same values the coming edge sees
      @(negedge aclk);
      in_reset  = !aresetn;
      ar_hs     = arvalid & arready;
      r_hs      = rvalid & rready;
      ar_addr_s = araddr;
      ar_len_s  = arlen;
      ar_hold   = ar_stall;
      r_hold    = r_stall;
      @(posedge aclk);
      #1;
      if (in_reset) begin
        burst_addr.delete();
        burst_last.delete();
        beat    = '0;
        arready = 1'b0;
        rvalid  = 1'b0;
        rlast   = 1'b0;
      end else begin
        if (ar_hs) begin
          burst_addr.push_back(ar_addr_s);
          burst_last.push_back(ar_len_s);
        end
        // Step through the oldest burst
        if (r_hs) begin
          if (rlast) begin
            void'(burst_addr.pop_front());
            void'(burst_last.pop_front());
            beat = '0;
          end else begin
            beat = beat + 8'd1;
          end
        end
        arready = (burst_addr.size() < queue_depth) && !ar_hold;
        // A beat on offer stays until it is taken
        if (!rvalid || r_hs) begin
          if (burst_addr.size() != 0) begin
            beat_addr = burst_addr[0] + addr_bits'(beat) * addr_bits'(data_bytes);
            rdata     = {beat_addr, ~beat_addr};
            rlast     = (beat == burst_last[0]);
            rvalid    = !r_hold;
          end else begin
            rvalid = 1'b0;
            rlast  = 1'b0;
          end
        end
      end
    end
  end

endmodule

// ==== test/tb_dma_rd.sv ====
// Read DMA testbench

`timescale 1ns/100ps

module tb_dma_rd;

  import dma_pkg::*;

  localparam int num_xfers = 6;

  logic                     aclk;
  logic                     aresetn;
  logic                     csr_req;
  logic                     csr_we;
  logic [reg_addr_bits-1:0] csr_addr;
  logic [31:0]              csr_wdata;
  logic                     csr_ack;
  logic [31:0]              csr_rdata;
  logic [addr_bits-1:0]     araddr;
  logic [7:0]               arlen;
  logic [2:0]               arsize;
  logic [1:0]               arburst;
  logic [3:0]               arcache;
  logic [2:0]               arprot;
  logic                     arvalid;
  logic                     arready;
  logic [data_bits-1:0]     rdata;
  logic                     rlast;
  logic                     rvalid;
  logic                     rready;
  logic [data_bits-1:0]     axis_tdata;
  logic                     axis_tlast;
  logic                     axis_tvalid;
  logic                     axis_tready;
  logic                     ar_stall;
  logic                     r_stall;

  // Transfer list in launch order
  int                   xfer_len    [num_xfers];
  logic [addr_bits-1:0] xfer_addr   [num_xfers];
  logic                 xfer_notify [num_xfers];
  // Launch as soon as the engine takes commands again
  logic                 overlap     [num_xfers];

  logic [31:0]          lfsr;
  int                   cycle_limit;
  int                   cycles      = 0;
  // Next expected stream beat
  int                   rx_xfer     = 0;
  int                   rx_beat     = 0;
  // Next expected address burst
  int                   ar_xfer     = 0;
  int                   ar_burst    = 0;
  int                   in_flight   = 0;
  logic                 was_stalled = 1'b0;
  logic [data_bits-1:0] held_data;
  logic                 held_last;

  dma_rd_top i_dut (.*);

  axi_mem_model i_mem (.*);

  initial begin
    aclk = 1'b0;
    forever #5 aclk = ~aclk;
  end

  ////////////////////////////////////////
  // Failure reporting
  ////////////////////////////////////////

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("Checks failed");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic report_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] want);
    stop_run($sformatf("FAILED %s got %h expected %h", name, got, want));
  endtask

  ////////////////////////////////////////
  // Random stalls
  ////////////////////////////////////////

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic lfsr_bit();
    logic fb;
    fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
    lfsr = {lfsr[30:0], fb};
    return fb;
  endfunction

  // One stall in four
  function automatic logic stall_draw();
    logic a;
    logic b;
    a = lfsr_bit();
    b = lfsr_bit();
    return a & b;
  endfunction

  initial begin
    ar_stall    = 1'b0;
    r_stall     = 1'b0;
    axis_tready = 1'b0;
    lfsr        = 32'h3cd8_c812;
    forever begin
      @(posedge aclk);
      #1;
      ar_stall    = stall_draw();
      r_stall     = stall_draw();
      axis_tready = !stall_draw();
    end
  end

  ////////////////////////////////////////
  // Host port
  ////////////////////////////////////////

  // Full four-phase access with read data taken while ack is high
  task automatic csr_access(input logic we, input logic [reg_addr_bits-1:0] addr,
                            input logic [31:0] wdata, output logic [31:0] value);
    @(posedge aclk);
    #1;
    assert (!csr_ack)
      else report_mismatch("csr_ack before request", 64'(csr_ack), 64'd0);
    csr_req   = 1'b1;
    csr_we    = we;
    csr_addr  = addr;
    csr_wdata = wdata;
    @(negedge aclk);
    while (!csr_ack) @(negedge aclk);
    value = csr_rdata;
    @(posedge aclk);
    #1;
    csr_req = 1'b0;
    @(negedge aclk);
    while (csr_ack) @(negedge aclk);
  endtask

  task automatic check_status(input int want_done);
    logic [31:0] value;
    csr_access(1'b0, reg_status, '0, value);
    assert (value[stat_busy_bit] == 1'b0)
      else report_mismatch("status busy", 64'(value[stat_busy_bit]), 64'd0);
    assert (value[stat_done_lsb +: done_cnt_bits] == done_cnt_bits'(want_done))
      else report_mismatch("status done count",
                           64'(value[stat_done_lsb +: done_cnt_bits]), 64'(want_done));
  endtask

  ////////////////////////////////////////
  // Monitors
  ////////////////////////////////////////

  // Sampled mid-cycle where every signal has settled
  always @(negedge aclk) begin
    logic [addr_bits-1:0] want_addr;
    logic                 want_last;
    int                   bursts;
    int                   want_len;
    cycles++;
    assert (cycles <= cycle_limit)
      else stop_run($sformatf("Timeout, run still going after %0d cycles", cycle_limit));
    if (aresetn) begin
      // R channel follows the sink
      assert (rready == axis_tready)
        else report_mismatch("rready", 64'(rready), 64'(axis_tready));
      // Stream beats in address order
      if (axis_tvalid && axis_tready) begin
        assert (rx_xfer < num_xfers) else stop_run("Stream beat after the last transfer");
        want_addr = xfer_addr[rx_xfer] + addr_bits'(rx_beat * data_bytes);
        want_last = (rx_beat == xfer_len[rx_xfer] / data_bytes - 1);
        assert (axis_tdata == {want_addr, ~want_addr})
          else report_mismatch("axis_tdata", axis_tdata, {want_addr, ~want_addr});
        assert (axis_tlast == want_last)
          else report_mismatch("axis_tlast", 64'(axis_tlast), 64'(want_last));
        if (want_last) begin
          rx_xfer++;
          rx_beat = 0;
        end else begin
          rx_beat++;
        end
      end
      // Stalled beat must not change
      if (was_stalled) begin
        assert (axis_tvalid)
          else report_mismatch("axis_tvalid under stall", 64'(axis_tvalid), 64'd1);
        assert (axis_tdata == held_data)
          else report_mismatch("axis_tdata under stall", axis_tdata, held_data);
        assert (axis_tlast == held_last)
          else report_mismatch("axis_tlast under stall", 64'(axis_tlast), 64'(held_last));
      end
      was_stalled = axis_tvalid & !axis_tready;
      held_data   = axis_tdata;
      held_last   = axis_tlast;
      // Burst address and length
      if (arvalid && arready) begin
        assert (ar_xfer < num_xfers) else stop_run("Address burst after the last transfer");
        bursts    = (xfer_len[ar_xfer] + burst_bytes - 1) / burst_bytes;
        want_addr = xfer_addr[ar_xfer] + addr_bits'(ar_burst * burst_bytes);
        want_len  = burst_len - 1;
        if (ar_burst == bursts - 1) begin
          want_len = burst_len - 1 - (bursts * burst_len - xfer_len[ar_xfer] / data_bytes);
        end
        assert (araddr == want_addr)
          else report_mismatch("araddr", 64'(araddr), 64'(want_addr));
        assert (arlen == 8'(want_len))
          else report_mismatch("arlen", 64'(arlen), 64'(want_len));
        // Eight bytes per beat
        assert (arsize == 3'd3)
          else report_mismatch("arsize", 64'(arsize), 64'd3);
        // INCR bursts with fixed cache and protection bits
        assert (arburst == 2'b01)
          else report_mismatch("arburst", 64'(arburst), 64'd1);
        assert (arcache == ar_cache_val)
          else report_mismatch("arcache", 64'(arcache), 64'(ar_cache_val));
        assert (arprot == ar_prot_val)
          else report_mismatch("arprot", 64'(arprot), 64'(ar_prot_val));
        in_flight++;
        if (ar_burst == bursts - 1) begin
          ar_xfer++;
          ar_burst = 0;
        end else begin
          ar_burst++;
        end
      end
      if (rvalid && rready && rlast) begin
        in_flight--;
      end
      assert (in_flight <= max_outstanding)
        else stop_run("More than four bursts outstanding on the read channel");
    end
  end

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial begin
    logic [31:0] rd_val;
    int          total_beats;
    int          notify_total;
    aresetn     = 1'b0;
    csr_req     = 1'b0;
    csr_we      = 1'b0;
    csr_addr    = '0;
    csr_wdata   = '0;
    xfer_len    = '{128, 8, 200, 1024, 136, 2048};
    xfer_addr   = '{32'h0000_1000, 32'h0001_0080, 32'h0002_0f00,
                    32'h4000_0000, 32'h8000_0180, 32'hfff0_0000};
    xfer_notify = '{1'b1, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0};
    overlap     = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1};
    total_beats  = 0;
    notify_total = 0;
    foreach (xfer_len[i]) begin
      total_beats += xfer_len[i] / data_bytes;
      if (xfer_notify[i]) notify_total++;
    end
    cycle_limit = total_beats * 20 + 2000;

    repeat (3) @(posedge aclk);
    #1;
    aresetn = 1'b1;
    @(negedge aclk);
    assert (!arvalid)
      else report_mismatch("arvalid after reset", 64'(arvalid), 64'd0);
    assert (!axis_tvalid)
      else report_mismatch("axis_tvalid after reset", 64'(axis_tvalid), 64'd0);
    assert (!csr_ack)
      else report_mismatch("csr_ack after reset", 64'(csr_ack), 64'd0);
    check_status(0);

    for (int k = 0; k < num_xfers; k++) begin
      if (!overlap[k]) wait (rx_xfer >= k);
      // Registers stay until the engine has taken the last command
      csr_access(1'b0, reg_status, '0, rd_val);
      while (rd_val[stat_busy_bit]) begin
        csr_access(1'b0, reg_status, '0, rd_val);
      end
      csr_access(1'b1, reg_src_addr, xfer_addr[k], rd_val);
      csr_access(1'b1, reg_len, 32'(xfer_len[k]), rd_val);
      csr_access(1'b1, reg_ctrl, {30'd0, xfer_notify[k], 1'b1}, rd_val);
    end

    wait (rx_xfer == num_xfers);
    assert (ar_xfer == num_xfers && in_flight == 0)
      else stop_run("Address bursts left over after the last stream beat");
    check_status(notify_total);
    $display("All checks passed");
    $finish;
  end

endmodule
